//--- Makefile
# Verilator build and run of the clock-gating testbench

VERILATOR ?= verilator
TOP       ?= clk_pm_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation completed successfully
JOBS      ?= 0
EXTRA     ?=

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and search the log for a pass"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_MSG JOBS EXTRA"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary --timing --assert -j $(JOBS) $(EXTRA) \
		-f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	rm -f $(LOG)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qxF "$(PASS_MSG)" $(LOG); then \
		echo "Result: PASS"; \
	else \
		echo "Result: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/clk_pm_tb.sv
`timescale 1ns/1ps

`include "clk_pm_params.svh"

module clk_pm_tb
    import clk_pm_pkg::*, wake_pkg::*;
();

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 4;
    localparam int SETTLE        = 5;
    localparam int WINDOW        = 10;
    localparam int FREE_ROUNDS   = 4;
    localparam int TOGGLES       = 8;
    localparam int TOGGLE_WIN    = 8;
    localparam int RST_WINDOW    = 25;
    localparam int RANDOM_CYCLES = 2000;
    localparam int SEQ_LEN = `RDC_PRE_CYCLES + `RDC_RST_CYCLES + `RDC_POST_CYCLES;

    // Sum of all directed and random phases in clock cycles
    localparam int TEST_CYCLES = RESET_CYCLES + SETTLE + FREE_ROUNDS * WINDOW +
                                 3 * (SETTLE + WINDOW) +
                                 SETTLE + TOGGLES * TOGGLE_WIN + 3 * (WINDOW + 2) +
                                 2 * SETTLE + RST_WINDOW +
                                 RANDOM_CYCLES + SETTLE;
    localparam int WATCHDOG_NS = (TEST_CYCLES + 100) * CLK_PERIOD;

    logic       clk;
    logic       cptra_rst_b;
    logic       psel;
    logic       clk_gate_en;
    logic       warm_rst_req;
    logic       cpu_halt_status;
    gen_wires_t generic_input_wires;
    logic       cptra_error_fatal;
    logic       cptra_in_debug_scan_mode;
    logic       cptra_dmi_reg_en_preq;
    logic       clk_cg;
    logic       soc_ifc_clk_cg;
    logic       rdc_clk_cg;
    logic       noncore_rst_b;

    // Reference model state, mirrors the flop stages named in the timing rules
    gen_wires_t m_sync1;
    gen_wires_t m_sync2;
    gen_wires_t m_wires_f;
    logic       m_req1;
    logic       m_req2;
    logic       m_req_d;
    int         m_seq_t;
    logic       m_rdc_dis;
    logic       m_nrst;
    logic       exp_cg;
    logic       exp_soc;
    logic       exp_rdc;

    int value_errors;
    int count_errors;
    int cg_pulses;
    int soc_pulses;
    int rdc_pulses;
    int rst_low_cycles;
    int snap_cg;
    int snap_soc;
    int snap_rdc;
    int snap_rst;

    clk_pm_top clk_pm_top_inst (
        .clk                      (clk),
        .cptra_rst_b              (cptra_rst_b),
        .psel                     (psel),
        .clk_gate_en              (clk_gate_en),
        .warm_rst_req             (warm_rst_req),
        .cpu_halt_status          (cpu_halt_status),
        .generic_input_wires      (generic_input_wires),
        .cptra_error_fatal        (cptra_error_fatal),
        .cptra_in_debug_scan_mode (cptra_in_debug_scan_mode),
        .cptra_dmi_reg_en_preq    (cptra_dmi_reg_en_preq),
        .clk_cg                   (clk_cg),
        .soc_ifc_clk_cg           (soc_ifc_clk_cg),
        .rdc_clk_cg               (rdc_clk_cg),
        .noncore_rst_b            (noncore_rst_b)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Watchdog sized from the total length of the test phases
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the test sequence finished");
        $display("Simulation failed");
        $finish;
    end

    // Phase of the warm-reset sequence for a given step count, 0 means idle
    function automatic rdc_state_e phase_of(input int t);
        if (t == 0) begin
            return RDC_IDLE;
        end else if (t <= `RDC_PRE_CYCLES) begin
            return RDC_PRE;
        end else if (t <= `RDC_PRE_CYCLES + `RDC_RST_CYCLES) begin
            return RDC_RST;
        end
        return RDC_POST;
    endfunction

    task automatic reset_model();
        m_sync1   = '0;
        m_sync2   = '0;
        m_wires_f = '0;
        m_req1    = 1'b0;
        m_req2    = 1'b0;
        m_req_d   = 1'b0;
        m_seq_t   = 0;
        m_rdc_dis = 1'b0;
        m_nrst    = 1'b1;
    endtask

    // One clock edge of the model
    // Expected enables come from the state before the edge and the inputs set up after
    // the previous edge, then every stage advances
    task automatic step_model();
        logic       change;
        logic       sleep;
        logic       req_rise;
        rdc_state_e state;
        change   = (m_sync2 != m_wires_f);
        sleep    = cpu_halt_status && !change && !cptra_error_fatal &&
                   !cptra_in_debug_scan_mode && !cptra_dmi_reg_en_preq;
        exp_cg   = !((clk_gate_en && sleep) || m_rdc_dis);
        exp_soc  = !((clk_gate_en && sleep && !psel) || m_rdc_dis);
        exp_rdc  = !m_rdc_dis;
        // Sequencer outputs are registered from the phase held before this edge
        state     = phase_of(m_seq_t);
        m_rdc_dis = (state != RDC_IDLE);
        m_nrst    = (state != RDC_RST);
        req_rise  = m_req2 && !m_req_d;
        if (m_seq_t == 0) begin
            m_seq_t = req_rise ? 1 : 0;
        end else if (m_seq_t == SEQ_LEN) begin
            m_seq_t = 0;
        end else begin
            m_seq_t++;
        end
        m_req_d   = m_req2;
        m_req2    = m_req1;
        m_req1    = warm_rst_req;
        m_wires_f = m_sync2;
        m_sync2   = m_sync1;
        m_sync1   = generic_input_wires;
    endtask

    task automatic compare_bit(input string name, input logic expected, input logic actual);
        assert (actual === expected) else begin
            $display("** Error at %0d ns: %s expected %0b actual %0b",
                     $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic expect_count(input string what, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("Wrong number of %s at %0d ns: expected %0d but counted %0d",
                     what, $time, expected, actual);
            count_errors++;
        end
    endtask

    // Model runs from the first edge after reset release
    // Outputs are sampled in the high phase, where a gated clock shows its latched enable
    initial begin
        reset_model();
        wait (cptra_rst_b === 1'b1);
        forever begin
            @(posedge clk);
            step_model();
            #10;
            compare_bit("clk_cg", exp_cg, clk_cg);
            compare_bit("soc_ifc_clk_cg", exp_soc, soc_ifc_clk_cg);
            compare_bit("rdc_clk_cg", exp_rdc, rdc_clk_cg);
            compare_bit("noncore_rst_b", m_nrst, noncore_rst_b);
            if (clk_cg === 1'b1) cg_pulses++;
            if (soc_ifc_clk_cg === 1'b1) soc_pulses++;
            if (rdc_clk_cg === 1'b1) rdc_pulses++;
            if (noncore_rst_b === 1'b0) rst_low_cycles++;
        end
    end

    // Inputs change 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic hold_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic set_levels(input logic halt, input logic gate_en, input logic sel);
        cpu_halt_status          = halt;
        clk_gate_en              = gate_en;
        psel                     = sel;
        cptra_error_fatal        = 1'b0;
        cptra_in_debug_scan_mode = 1'b0;
        cptra_dmi_reg_en_preq    = 1'b0;
    endtask

    task automatic take_snapshot();
        snap_cg  = cg_pulses;
        snap_soc = soc_pulses;
        snap_rdc = rdc_pulses;
        snap_rst = rst_low_cycles;
    endtask

    task automatic check_deltas(input string label, input int cg_exp, input int soc_exp,
                                input int rdc_exp);
        expect_count({label, " clk_cg pulses"}, cg_exp, cg_pulses - snap_cg);
        expect_count({label, " soc_ifc_clk_cg pulses"}, soc_exp, soc_pulses - snap_soc);
        expect_count({label, " rdc_clk_cg pulses"}, rdc_exp, rdc_pulses - snap_rdc);
    endtask

    // Counts pulses of the gated clocks over a window with the inputs held
    task automatic run_window(input string label, input int cycles, input int cg_exp,
                              input int soc_exp, input int rdc_exp);
        take_snapshot();
        hold_cycles(cycles);
        check_deltas(label, cg_exp, soc_exp, rdc_exp);
    endtask

    task automatic drive_wake_source(input int src, input logic value);
        case (src)
            0:       cptra_error_fatal        = value;
            1:       cptra_in_debug_scan_mode = value;
            default: cptra_dmi_reg_en_preq    = value;
        endcase
    endtask

    // A running core keeps every clock on, whatever else is driven
    task automatic test_free_running();
        set_levels(1'b0, 1'b1, 1'b0);
        hold_cycles(SETTLE);
        repeat (FREE_ROUNDS) begin
            psel                = ($urandom % 2) != 0;
            clk_gate_en         = ($urandom % 2) != 0;
            generic_input_wires = {$urandom, $urandom};
            run_window("running core", WINDOW, WINDOW, WINDOW, WINDOW);
        end
    endtask

    task automatic test_halt_gating();
        set_levels(1'b1, 1'b1, 1'b0);
        hold_cycles(SETTLE);
        run_window("halted and gated", WINDOW, 0, 0, WINDOW);
        clk_gate_en = 1'b0;
        hold_cycles(SETTLE);
        run_window("halted without gating", WINDOW, WINDOW, WINDOW, WINDOW);
    endtask

    task automatic test_psel_wake();
        set_levels(1'b1, 1'b1, 1'b1);
        hold_cycles(SETTLE);
        run_window("halted with psel", WINDOW, 0, WINDOW, WINDOW);
    endtask

    task automatic test_wake_sources();
        int bit_idx;
        set_levels(1'b1, 1'b1, 1'b0);
        hold_cycles(SETTLE);
        // Each toggle shows as one change cycle after the synchronizer and change flop
        repeat (TOGGLES) begin
            bit_idx = int'($urandom % `GEN_WIRE_W);
            generic_input_wires[bit_idx] = ~generic_input_wires[bit_idx];
            run_window("wire toggle", TOGGLE_WIN, 1, 1, TOGGLE_WIN);
        end
        for (int src = 0; src < 3; src++) begin
            drive_wake_source(src, 1'b1);
            hold_cycles(1);
            run_window("level wake source", WINDOW, WINDOW, WINDOW, WINDOW);
            drive_wake_source(src, 1'b0);
            hold_cycles(1);
        end
    endtask

    task automatic test_warm_reset();
        set_levels(1'b0, 1'b1, 1'b0);
        hold_cycles(SETTLE);
        take_snapshot();
        warm_rst_req = 1'b1;
        hold_cycles(4);
        // Second rising edge lands inside the running sequence
        warm_rst_req = 1'b0;
        hold_cycles(2);
        warm_rst_req = 1'b1;
        hold_cycles(RST_WINDOW - 6);
        check_deltas("warm reset", RST_WINDOW - SEQ_LEN, RST_WINDOW - SEQ_LEN,
                     RST_WINDOW - SEQ_LEN);
        expect_count("non-core reset cycles", `RDC_RST_CYCLES, rst_low_cycles - snap_rst);
        warm_rst_req = 1'b0;
        hold_cycles(SETTLE);
    endtask

    // Biased random levels so that sleep, wake and warm reset all occur
    task automatic test_random_mix();
        int bit_idx;
        repeat (RANDOM_CYCLES) begin
            cpu_halt_status          = ($urandom % 4) != 0;
            clk_gate_en              = ($urandom % 4) != 0;
            psel                     = ($urandom % 4) == 0;
            cptra_error_fatal        = ($urandom % 32) == 0;
            cptra_in_debug_scan_mode = ($urandom % 32) == 0;
            cptra_dmi_reg_en_preq    = ($urandom % 16) == 0;
            if (($urandom % 8) == 0) begin
                bit_idx = int'($urandom % `GEN_WIRE_W);
                generic_input_wires[bit_idx] = ~generic_input_wires[bit_idx];
            end
            if (($urandom % 24) == 0) begin
                warm_rst_req = ~warm_rst_req;
            end
            next_cycle();
        end
    endtask

    initial begin
        cptra_rst_b              = 1'b0;
        psel                     = 1'b0;
        clk_gate_en              = 1'b0;
        warm_rst_req             = 1'b0;
        cpu_halt_status          = 1'b0;
        generic_input_wires      = '0;
        cptra_error_fatal        = 1'b0;
        cptra_in_debug_scan_mode = 1'b0;
        cptra_dmi_reg_en_preq    = 1'b0;
        value_errors             = 0;
        count_errors             = 0;
        cg_pulses                = 0;
        soc_pulses               = 0;
        rdc_pulses               = 0;
        rst_low_cycles           = 0;
        void'($urandom(32'h451bf8f7));
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        cptra_rst_b = 1'b1;

        test_free_running();
        test_halt_gating();
        test_psel_wake();
        test_wake_sources();
        test_warm_reset();
        test_random_mix();
        hold_cycles(SETTLE);

        $display("Error counts: %0d wrong values, %0d wrong pulse counts",
                 value_errors, count_errors);
        if (value_errors == 0 && count_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- logic/clk_gate.sv
`timescale 1ns/1ps

module clk_gate
    import wake_pkg::*;
(
    input  logic       clk,
    input  logic       cptra_rst_b,
    input  logic       psel,
    input  logic       clk_gate_en,
    input  logic       rdc_clk_dis,
    input  logic       cpu_halt_status,
    input  gen_wires_t generic_input_wires,
    input  logic       cptra_error_fatal,
    input  logic       cptra_in_debug_scan_mode,
    // JTAG register access in progress
    input  logic       cptra_dmi_reg_en_preq,
    output logic       clk_cg,
    output logic       soc_ifc_clk_cg,
    output logic       rdc_clk_cg
);

    gen_wires_t generic_input_wires_f;
    logic       change_in_generic_wires;
    logic       sleep_condition;
    logic       disable_clk;
    logic       disable_soc_ifc_clk;

    // One more flop on the synchronized wires to see a change
    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            generic_input_wires_f <= '0;
        end else begin
            generic_input_wires_f <= generic_input_wires;
        end
    end

    // Any differing bit between the bundle and its delayed copy is a wake event
    // It lasts exactly one cycle per toggle
    assign change_in_generic_wires = |(generic_input_wires ^ generic_input_wires_f);

    // The core may sleep only when halted with no wake source pending
    assign sleep_condition = cpu_halt_status && !change_in_generic_wires &&
                             !cptra_error_fatal && !cptra_in_debug_scan_mode &&
                             !cptra_dmi_reg_en_preq;

    // The warm-reset sequencer overrides gating policy and stops everything
    assign disable_clk = (clk_gate_en && sleep_condition) || rdc_clk_dis;

    // The SoC interface keeps its clock while psel is high
    assign disable_soc_ifc_clk = (clk_gate_en && sleep_condition && !psel) || rdc_clk_dis;

    // Three gating cells, enables latched in the low phase
    icg_cell core_icg (
        .clk    (clk),
        .en     (!disable_clk),
        .clk_cg (clk_cg)
    );

    icg_cell soc_ifc_icg (
        .clk    (clk),
        .en     (!disable_soc_ifc_clk),
        .clk_cg (soc_ifc_clk_cg)
    );

    // Only the warm-reset sequence stops this one
    icg_cell rdc_icg (
        .clk    (clk),
        .en     (!rdc_clk_dis),
        .clk_cg (rdc_clk_cg)
    );

    // Frozen crossing clocks leave no pulse on any gated clock in the next cycle
    // Sampled at the falling edge a gated clock still shows the enable latched for this cycle
    a_rdc_forces_off: assert property (
        @(negedge clk) disable iff (!cptra_rst_b)
        $past(rdc_clk_dis) |-> !clk_cg && !soc_ifc_clk_cg && !rdc_clk_cg
    );

    // Without a bus access the SoC interface clock never pulses while the core clock is stopped
    a_soc_follows_core: assert property (
        @(negedge clk) disable iff (!cptra_rst_b)
        !clk_cg && !$past(psel) |-> !soc_ifc_clk_cg
    );

endmodule

//--- logic/clk_pm_params.svh
`ifndef CLK_PM_PARAMS_SVH
`define CLK_PM_PARAMS_SVH

// Width of the generic input wire bundle coming from the SoC
`define GEN_WIRE_W 64

// Warm-reset sequence lengths in clk cycles

// Cycles the crossing clocks are held off before the non-core reset asserts
`define RDC_PRE_CYCLES 4

// Cycles the non-core reset is held low
`define RDC_RST_CYCLES 6

// Cycles the crossing clocks stay off after the non-core reset releases
`define RDC_POST_CYCLES 4

`endif

//--- logic/clk_pm_pkg.sv
package clk_pm_pkg;

    `include "clk_pm_params.svh"

    // Phases of the warm-reset sequence
    // IDLE waits for a request edge, PRE freezes the crossing clocks,
    // RST holds the non-core reset and POST keeps the clocks frozen after release
    typedef enum logic [1:0] {
        RDC_IDLE = 2'b00,
        RDC_PRE  = 2'b01,
        RDC_RST  = 2'b10,
        RDC_POST = 2'b11
    } rdc_state_e;

    // Longest phase sets the width of the shared down-counter
    localparam int RDC_MAX_CYCLES =
        (`RDC_PRE_CYCLES > `RDC_RST_CYCLES) ?
        ((`RDC_PRE_CYCLES > `RDC_POST_CYCLES) ? `RDC_PRE_CYCLES : `RDC_POST_CYCLES) :
        ((`RDC_RST_CYCLES > `RDC_POST_CYCLES) ? `RDC_RST_CYCLES : `RDC_POST_CYCLES);

    // The counter is loaded with a phase length minus one
    localparam int RDC_CNT_W = (RDC_MAX_CYCLES > 1) ? $clog2(RDC_MAX_CYCLES) : 1;

    typedef logic [RDC_CNT_W-1:0] rdc_cnt_t;

endpackage

//--- logic/clk_pm_top.sv
`timescale 1ns/1ps

module clk_pm_top
    import wake_pkg::*;
(
    input  logic       clk,
    input  logic       cptra_rst_b,
    input  logic       psel,
    input  logic       clk_gate_en,
    // Level request from another reset domain, its rising edge starts a sequence
    input  logic       warm_rst_req,
    input  logic       cpu_halt_status,
    // Asynchronous wires from the SoC
    input  gen_wires_t generic_input_wires,
    input  logic       cptra_error_fatal,
    input  logic       cptra_in_debug_scan_mode,
    input  logic       cptra_dmi_reg_en_preq,
    output logic       clk_cg,
    output logic       soc_ifc_clk_cg,
    output logic       rdc_clk_cg,
    output logic       noncore_rst_b
);

    gen_wires_t gen_wires_s;
    logic       warm_rst_req_s;
    logic       rdc_clk_dis;

    // Bring the wire bundle into the clk domain
    sync_2ff #(
        .payload_t (gen_wires_t)
    ) gen_wires_sync (
        .clk         (clk),
        .cptra_rst_b (cptra_rst_b),
        .d           (generic_input_wires),
        .q           (gen_wires_s)
    );

    // Same synchronizer for the single-bit warm reset request
    sync_2ff #(
        .payload_t (logic)
    ) warm_rst_sync (
        .clk         (clk),
        .cptra_rst_b (cptra_rst_b),
        .d           (warm_rst_req),
        .q           (warm_rst_req_s)
    );

    // Warm-reset sequencer
    rdc_seq rdc_seq_inst (
        .clk           (clk),
        .cptra_rst_b   (cptra_rst_b),
        .warm_rst_req  (warm_rst_req_s),
        .rdc_clk_dis   (rdc_clk_dis),
        .noncore_rst_b (noncore_rst_b)
    );

    // Gate decision and the clock gating cells
    clk_gate clk_gate_inst (
        .clk                      (clk),
        .cptra_rst_b              (cptra_rst_b),
        .psel                     (psel),
        .clk_gate_en              (clk_gate_en),
        .rdc_clk_dis              (rdc_clk_dis),
        .cpu_halt_status          (cpu_halt_status),
        .generic_input_wires      (gen_wires_s),
        .cptra_error_fatal        (cptra_error_fatal),
        .cptra_in_debug_scan_mode (cptra_in_debug_scan_mode),
        .cptra_dmi_reg_en_preq    (cptra_dmi_reg_en_preq),
        .clk_cg                   (clk_cg),
        .soc_ifc_clk_cg           (soc_ifc_clk_cg),
        .rdc_clk_cg               (rdc_clk_cg)
    );

endmodule

//--- logic/icg_cell.sv
`timescale 1ns/1ps

module icg_cell (
    input  logic clk,
    input  logic en,
    output logic clk_cg
);

    logic en_lat;

    // Latch is open while clk is low and closes on the rising edge
    // so the enable cannot change during the high phase
    always_latch begin
        if (!clk) begin
            en_lat = en;
        end
    end

    // Gated clock only pulses when the latched enable is high
    assign clk_cg = clk & en_lat;

endmodule

//--- logic/rdc_seq.sv
`timescale 1ns/1ps

`include "clk_pm_params.svh"

module rdc_seq
    import clk_pm_pkg::*;
(
    input  logic clk,
    input  logic cptra_rst_b,
    input  logic warm_rst_req,
    output logic rdc_clk_dis,
    output logic noncore_rst_b
);

    rdc_state_e state;
    rdc_cnt_t   cnt;
    logic       req_d;
    logic       req_rise;

    // Delayed copy of the synchronized request for edge detection
    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            req_d <= 1'b0;
        end else begin
            req_d <= warm_rst_req;
        end
    end

    // A request only counts on its rising edge
    assign req_rise = warm_rst_req & ~req_d;

    // Phase machine with a single down-counter
    // Each phase loads its length minus one and moves on when the count hits zero
    // Request edges seen outside IDLE are dropped
    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            state <= RDC_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                RDC_IDLE: begin
                    if (req_rise) begin
                        state <= RDC_PRE;
                        cnt   <= rdc_cnt_t'(`RDC_PRE_CYCLES - 1);
                    end
                end
                RDC_PRE: begin
                    if (cnt == '0) begin
                        state <= RDC_RST;
                        cnt   <= rdc_cnt_t'(`RDC_RST_CYCLES - 1);
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                RDC_RST: begin
                    if (cnt == '0) begin
                        state <= RDC_POST;
                        cnt   <= rdc_cnt_t'(`RDC_POST_CYCLES - 1);
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: begin
                    // Last phase returns to IDLE and the clocks come back
                    if (cnt == '0) begin
                        state <= RDC_IDLE;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
            endcase
        end
    end

    // Outputs trail the state by one edge so they leave a flop cleanly
    // The clocks stay off for the whole sequence, the reset only during RST
    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            rdc_clk_dis   <= 1'b0;
            noncore_rst_b <= 1'b1;
        end else begin
            rdc_clk_dis   <= (state != RDC_IDLE);
            noncore_rst_b <= (state != RDC_RST);
        end
    end

    // The non-core reset asserts only after the crossing clocks have been off
    // for the whole pre phase
    a_rst_inside_clk_dis: assert property (
        @(posedge clk) disable iff (!cptra_rst_b)
        !noncore_rst_b |-> rdc_clk_dis && $past(rdc_clk_dis, `RDC_PRE_CYCLES)
    );

    // The crossing clocks only freeze two edges after a request edge
    a_no_spurious_start: assert property (
        @(posedge clk) disable iff (!cptra_rst_b)
        $rose(rdc_clk_dis) |-> $past(req_rise, 2)
    );

endmodule

//--- logic/sync_2ff.sv
`timescale 1ns/1ps

module sync_2ff #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     cptra_rst_b,
    input  payload_t d,
    output payload_t q
);

    // First stage may go metastable and is never used outside this module
    payload_t meta_q;

    // Two flops back to back bring the asynchronous value into the clk domain
    // A value captured at one edge reaches q one edge later
    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            meta_q <= '0;
            q      <= '0;
        end else begin
            meta_q <= d;
            q      <= meta_q;
        end
    end

endmodule

//--- logic/wake_pkg.sv
package wake_pkg;

    `include "clk_pm_params.svh"

    // Bundle of generic input wires from the SoC
    // Any change on a synchronized bit is a wake event for the core clock
    typedef logic [`GEN_WIRE_W-1:0] gen_wires_t;

endpackage

//--- src.f
+incdir+logic
logic/clk_pm_pkg.sv
logic/wake_pkg.sv
logic/sync_2ff.sv
logic/icg_cell.sv
logic/rdc_seq.sv
logic/clk_gate.sv
logic/clk_pm_top.sv
bench/clk_pm_tb.sv
